// ==== src.f ====
+incdir+tests
hw/icm_rsp_pkg.sv
hw/icm_rsp_ctrl.sv
hw/icm_entry_merge.sv
hw/icm_rsp_top.sv
tests/icm_rsp_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f src.f --top-module icm_rsp_tb -o icm_rsp_sim &&
./obj_dir/icm_rsp_sim | tee /dev/stderr | grep "^all tests passed$" > /dev/null &&
echo "simulation run ok" || { echo "simulation run not ok"; exit 1; }

// ==== tests/icm_rsp_tb_cases.svh ====
// response rows for the ICM response stage testbench
// rows run in table order and share reorder slots by tag, so later rows
// depend on the halves left behind by earlier ones
// expected counts assume every slot starts with a collected count of zero

`ifndef icm_rsp_tb_cases_svh
`define icm_rsp_tb_cases_svh

localparam int num_cases = 9;

case_t cases [num_cases];

task automatic set_case(
    input int                                      i,
    input logic                                    hit,
    input logic [icm_rsp_pkg::count_width-1:0]     idx,
    input logic [icm_rsp_pkg::count_width-1:0]     cmax,
    input logic [icm_rsp_pkg::req_tag_width-1:0]   tag,
    input logic [icm_rsp_pkg::phys_addr_width-1:0] phys,
    input logic [icm_rsp_pkg::icm_addr_width-1:0]  icm,
    input int                                      full_cycles,
    input int                                      dma_delay,
    input logic [icm_rsp_pkg::count_width-1:0]     exp_count,
    input icm_rsp_pkg::req_desc_t                  exp_desc,
    input icm_rsp_pkg::dma_head_t                  exp_dma
);
    case_t c;
    c.hit         = hit;
    c.idx         = idx;
    c.cmax        = cmax;
    c.tag         = tag;
    c.phys        = phys;
    c.icm         = icm;
    c.full_cycles = full_cycles;
    c.dma_delay   = dma_delay;
    c.exp_count   = exp_count;
    c.exp_desc    = exp_desc;
    c.exp_dma     = exp_dma;
    cases[i]      = c;
endtask

task automatic load_cases();
    // row, hit, index, count_max, tag, phys addr, icm addr, full cycles, dma delay,
    // expected collected count, expected descriptor, expected DMA head
    set_case(0, 1'b1, 2'd0, 2'd1, 5'd3, 32'h0001_0000, 32'h8000_0000, 0, 0, 2'd1,
             {2'd1, 2'd0, 5'd3, 32'h0001_0000, 32'h8000_0000}, 64'd0);
    set_case(1, 1'b1, 2'd1, 2'd1, 5'd3, 32'h0001_0040, 32'h8000_0008, 0, 0, 2'd2,
             {2'd1, 2'd1, 5'd3, 32'h0001_0040, 32'h8000_0008}, 64'd0);
    set_case(2, 1'b1, 2'd0, 2'd0, 5'd7, 32'h0003_2000, 32'h8001_0000, 3, 0, 2'd1,
             {2'd0, 2'd0, 5'd7, 32'h0003_2000, 32'h8001_0000}, 64'd0);
    set_case(3, 1'b0, 2'd0, 2'd0, 5'd9, 32'h0002_1000, 32'h8002_0000, 2, 3, 2'd0,
             {2'd0, 2'd0, 5'd9, 32'h0002_1000, 32'h8002_0000}, {32'h0002_1000, 32'd8});
    set_case(4, 1'b0, 2'd1, 2'd1, 5'd10, 32'h0002_2008, 32'h8002_0008, 0, 0, 2'd0,
             {2'd1, 2'd1, 5'd10, 32'h0002_2008, 32'h8002_0008}, {32'h0002_2008, 32'd8});
    set_case(5, 1'b1, 2'd1, 2'd1, 5'd7, 32'h0003_2040, 32'h8001_0008, 0, 0, 2'd2,
             {2'd1, 2'd1, 5'd7, 32'h0003_2040, 32'h8001_0008}, 64'd0);
    // index out of range clears the slot
    set_case(6, 1'b1, 2'd2, 2'd1, 5'd12, 32'h0004_0000, 32'h8003_0000, 1, 0, 2'd0,
             {2'd1, 2'd2, 5'd12, 32'h0004_0000, 32'h8003_0000}, 64'd0);
    set_case(7, 1'b1, 2'd0, 2'd1, 5'd31, 32'h0005_ff00, 32'h8004_0000, 0, 0, 2'd1,
             {2'd1, 2'd0, 5'd31, 32'h0005_ff00, 32'h8004_0000}, 64'd0);
    set_case(8, 1'b0, 2'd0, 2'd0, 5'd0, 32'h0006_0008, 32'h8005_0000, 0, 1, 2'd0,
             {2'd0, 2'd0, 5'd0, 32'h0006_0008, 32'h8005_0000}, {32'h0006_0008, 32'd8});
endtask

`endif

// ==== tests/icm_rsp_tb.sv ====
// testbench for the ICM response stage
// the next row is held on the response bus while the current one is
// processed, so every row after the first is a back-to-back response
// reorder memory, queue flags and the DMA responder are modeled here

module icm_rsp_tb;

    localparam int wait_limit = 64;

    typedef struct {
        logic                                    hit;
        logic [icm_rsp_pkg::count_width-1:0]     idx;
        logic [icm_rsp_pkg::count_width-1:0]     cmax;
        logic [icm_rsp_pkg::req_tag_width-1:0]   tag;
        logic [icm_rsp_pkg::phys_addr_width-1:0] phys;
        logic [icm_rsp_pkg::icm_addr_width-1:0]  icm;
        int                                      full_cycles;
        int                                      dma_delay;
        logic [icm_rsp_pkg::count_width-1:0]     exp_count;
        icm_rsp_pkg::req_desc_t                  exp_desc;
        icm_rsp_pkg::dma_head_t                  exp_dma;
    } case_t;

    logic                                  clk;
    logic                                  rst;
    logic                                  rsp_valid;
    icm_rsp_pkg::rsp_head_t                rsp_head;
    logic [icm_rsp_pkg::entry_width-1:0]   rsp_data;
    logic                                  rsp_ready;
    logic                                  rob_wen;
    logic [icm_rsp_pkg::req_tag_width-1:0] rob_addr;
    icm_rsp_pkg::rob_slot_t                rob_din;
    icm_rsp_pkg::rob_slot_t                rob_dout;
    logic                                  hit_wr_en;
    icm_rsp_pkg::req_desc_t                hit_din;
    logic                                  hit_prog_full;
    logic                                  miss_wr_en;
    icm_rsp_pkg::req_desc_t                miss_din;
    logic                                  miss_prog_full;
    logic                                  dma_req_valid;
    icm_rsp_pkg::dma_head_t                dma_req_head;
    logic                                  dma_req_last;
    logic                                  dma_req_ready;

    int     errors;
    int     passed;
    logic   timed_out;
    integer seed;

    `include "icm_rsp_tb_cases.svh"

    logic [icm_rsp_pkg::entry_width-1:0] case_data [num_cases];

    // expected slot halves, updated by the merge rules after each hit
    logic [icm_rsp_pkg::entry_width-1:0] shadow_upper [32];
    logic [icm_rsp_pkg::entry_width-1:0] shadow_lower [32];

    icm_rsp_pkg::rob_slot_t rob_mem [32];

    icm_rsp_top uut (
        .clk            (clk),
        .rst            (rst),
        .rsp_valid      (rsp_valid),
        .rsp_head       (rsp_head),
        .rsp_data       (rsp_data),
        .rsp_ready      (rsp_ready),
        .rob_wen        (rob_wen),
        .rob_addr       (rob_addr),
        .rob_din        (rob_din),
        .rob_dout       (rob_dout),
        .hit_wr_en      (hit_wr_en),
        .hit_din        (hit_din),
        .hit_prog_full  (hit_prog_full),
        .miss_wr_en     (miss_wr_en),
        .miss_din       (miss_din),
        .miss_prog_full (miss_prog_full),
        .dma_req_valid  (dma_req_valid),
        .dma_req_head   (dma_req_head),
        .dma_req_last   (dma_req_last),
        .dma_req_ready  (dma_req_ready)
    );

    // every slot starts with a pattern built from its own address
    function automatic icm_rsp_pkg::rob_slot_t fill_slot(input logic [4:0] a);
        icm_rsp_pkg::rob_slot_t s;
        s.collected = 2'd0;
        s.upper     = {27'h5a5a5a5, a, 27'h1234567, a};
        s.lower     = {27'h0c0ffee, a, 27'h7654321, a};
        return s;
    endfunction

    // reorder memory, asynchronous read
    assign rob_dout = rob_mem[rob_addr];

    always @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < 32; a++) begin
                rob_mem[a] <= fill_slot(5'(a));
            end
        end else if (rob_wen) begin
            rob_mem[rob_addr] <= rob_din;
        end
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_bits(input string name, input logic [129:0] got,
                              input logic [129:0] expected);
        assert (got === expected) else begin
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        assert (got == expected) else begin
            $display("Mismatch at %0t: %s count got %0d expected %0d",
                     $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    // puts row n on the response bus, or idles the bus past the last row
    task automatic drive_next(input int n);
        if (n < num_cases) begin
            rsp_valid                 = 1'b1;
            rsp_head.hit              = cases[n].hit;
            rsp_head.desc.count_max   = cases[n].cmax;
            rsp_head.desc.count_index = cases[n].idx;
            rsp_head.desc.req_tag     = cases[n].tag;
            rsp_head.desc.phys_addr   = cases[n].phys;
            rsp_head.desc.icm_addr    = cases[n].icm;
            rsp_data                  = case_data[n];
        end else begin
            rsp_valid = 1'b0;
        end
    endtask

    // called a little after a falling edge with row r on the bus
    task automatic run_case(input int r);
        case_t                  c;
        icm_rsp_pkg::rob_slot_t exp_slot;
        int                     cyc;
        int                     hit_n;
        int                     miss_n;
        int                     rob_n;
        int                     valid_n;
        int                     miss_cyc;
        int                     errs_start;
        logic                   done;
        c          = cases[r];
        errs_start = errors;
        cyc        = 0;
        while (!rsp_ready && !timed_out) begin
            @(negedge clk);
            #1;
            cyc++;
            if (cyc > wait_limit) begin
                $display("timeout: case %0d was never taken, rsp_ready stayed low", r);
                timed_out = 1'b1;
            end
        end
        if (timed_out) begin
            return;
        end

        exp_slot.collected = c.exp_count;
        case (c.idx)
            2'd0: begin
                exp_slot.upper = shadow_upper[c.tag];
                exp_slot.lower = case_data[r];
            end
            2'd1: begin
                exp_slot.upper = case_data[r];
                exp_slot.lower = shadow_lower[c.tag];
            end
            default: begin
                exp_slot.upper = '0;
                exp_slot.lower = '0;
            end
        endcase

        // response taken on this edge
        @(posedge clk);
        cyc      = 0;
        hit_n    = 0;
        miss_n   = 0;
        rob_n    = 0;
        valid_n  = 0;
        miss_cyc = -2;
        done     = 1'b0;
        while (!done && !timed_out) begin
            @(negedge clk);
            if (cyc == 0) begin
                drive_next(r + 1);
            end
            hit_prog_full  = c.hit && (cyc < c.full_cycles);
            miss_prog_full = !c.hit && (cyc < c.full_cycles);
            dma_req_ready  = (valid_n >= c.dma_delay);
            #1;
            if (rsp_ready) begin
                done = 1'b1;
            end else begin
                check_true(!(hit_prog_full && (hit_wr_en || rob_wen)),
                           "hit queue or reorder write while hit_prog_full was high");
                check_true(!(miss_prog_full && miss_wr_en),
                           "miss queue write while miss_prog_full was high");
                check_true(rob_wen === hit_wr_en,
                           "reorder write and hit queue write fell in different cycles");
                if (hit_wr_en) begin
                    hit_n++;
                    check_bits("hit_din", 130'(hit_din), 130'(c.exp_desc));
                end
                if (rob_wen) begin
                    rob_n++;
                    check_bits("rob_addr", 130'(rob_addr), 130'(c.tag));
                    check_bits("rob_din", 130'(rob_din), 130'(exp_slot));
                end
                if (miss_wr_en) begin
                    miss_n++;
                    miss_cyc = cyc;
                    check_bits("miss_din", 130'(miss_din), 130'(c.exp_desc));
                end
                if (dma_req_valid) begin
                    if (valid_n == 0) begin
                        check_true(cyc == miss_cyc + 1,
                                   "dma_req_valid did not rise the cycle after the miss write");
                    end
                    valid_n++;
                    check_true(miss_n == 1, "DMA request raised before the miss queue write");
                    check_bits("dma_req_head", 130'(dma_req_head), 130'(c.exp_dma));
                    check_bits("dma_req_last", 130'(dma_req_last), 130'(1'b1));
                end
            end
            cyc++;
            if (!done && cyc > wait_limit) begin
                $display("timeout: case %0d never returned to idle", r);
                timed_out = 1'b1;
            end
        end
        if (timed_out) begin
            return;
        end

        check_count("hit_wr_en", hit_n, c.hit ? 1 : 0);
        check_count("rob_wen", rob_n, c.hit ? 1 : 0);
        check_count("miss_wr_en", miss_n, c.hit ? 0 : 1);
        check_count("dma_req_valid cycles", valid_n, c.hit ? 0 : c.dma_delay + 1);
        if (c.hit) begin
            shadow_upper[c.tag] = exp_slot.upper;
            shadow_lower[c.tag] = exp_slot.lower;
        end
        $display("case %0d %s tag %0d: %s", r, c.hit ? "hit" : "miss", c.tag,
                 (errors == errs_start) ? "ok" : "error");
        if (errors == errs_start) begin
            passed++;
        end
    endtask

    initial begin
        icm_rsp_pkg::rob_slot_t init_slot;
        int                     errs_start;
        errors         = 0;
        passed         = 0;
        timed_out      = 1'b0;
        seed           = 4254;
        rst            = 1'b1;
        rsp_valid      = 1'b0;
        rsp_head       = '0;
        rsp_data       = '0;
        hit_prog_full  = 1'b0;
        miss_prog_full = 1'b0;
        dma_req_ready  = 1'b0;
        load_cases();
        for (int i = 0; i < num_cases; i++) begin
            case_data[i] = {$random(seed), $random(seed)};
        end
        for (int a = 0; a < 32; a++) begin
            init_slot       = fill_slot(5'(a));
            shadow_upper[a] = init_slot.upper;
            shadow_lower[a] = init_slot.lower;
        end

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        errs_start = errors;
        check_bits("rsp_ready", 130'(rsp_ready), 130'(1'b1));
        check_bits("hit_wr_en", 130'(hit_wr_en), 130'(1'b0));
        check_bits("miss_wr_en", 130'(miss_wr_en), 130'(1'b0));
        check_bits("rob_wen", 130'(rob_wen), 130'(1'b0));
        check_bits("dma_req_valid", 130'(dma_req_valid), 130'(1'b0));
        check_bits("dma_req_last", 130'(dma_req_last), 130'(1'b0));
        $display("after reset: %s", (errors == errs_start) ? "ok" : "error");
        if (errors == errs_start) begin
            passed++;
        end

        @(negedge clk);
        drive_next(0);
        #1;
        for (int r = 0; r < num_cases && !timed_out; r++) begin
            run_case(r);
        end

        $display("%0d of %0d tests ok, %0d errors", passed, num_cases + 1, errors);
        if (errors == 0 && !timed_out && passed == num_cases + 1) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== hw/icm_rsp_top.sv ====
// ICM translation cache response stage, MTT entries only
// takes one lookup response at a time through a valid/ready handshake
// hits go to the hit queue and the reorder buffer, misses to the miss queue
// and a single-beat DMA read
// the reorder memory itself sits outside and must have asynchronous read

module icm_rsp_top (
    input  logic                                  clk,
    input  logic                                  rst,

    // lookup response
    input  logic                                  rsp_valid,
    input  icm_rsp_pkg::rsp_head_t                rsp_head,
    input  logic [icm_rsp_pkg::entry_width-1:0]   rsp_data,
    output logic                                  rsp_ready,

    // reorder buffer
    output logic                                  rob_wen,
    output logic [icm_rsp_pkg::req_tag_width-1:0] rob_addr,
    output icm_rsp_pkg::rob_slot_t                rob_din,
    input  icm_rsp_pkg::rob_slot_t                rob_dout,

    // hit queue
    output logic                                  hit_wr_en,
    output icm_rsp_pkg::req_desc_t                hit_din,
    input  logic                                  hit_prog_full,

    // miss queue
    output logic                                  miss_wr_en,
    output icm_rsp_pkg::req_desc_t                miss_din,
    input  logic                                  miss_prog_full,

    // DMA read request
    output logic                                  dma_req_valid,
    output icm_rsp_pkg::dma_head_t                dma_req_head,
    output logic                                  dma_req_last,
    input  logic                                  dma_req_ready
);

    logic                   capture;
    logic                   commit;
    icm_rsp_pkg::req_desc_t cur_desc;

    icm_rsp_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .rsp_valid      (rsp_valid),
        .rsp_head       (rsp_head),
        .rsp_ready      (rsp_ready),
        .capture        (capture),
        .commit         (commit),
        .cur_desc       (cur_desc),
        .hit_wr_en      (hit_wr_en),
        .hit_din        (hit_din),
        .hit_prog_full  (hit_prog_full),
        .miss_wr_en     (miss_wr_en),
        .miss_din       (miss_din),
        .miss_prog_full (miss_prog_full),
        .dma_req_valid  (dma_req_valid),
        .dma_req_head   (dma_req_head),
        .dma_req_last   (dma_req_last),
        .dma_req_ready  (dma_req_ready)
    );

    // data path for hit entries
    icm_entry_merge u_merge (
        .clk      (clk),
        .rst      (rst),
        .capture  (capture),
        .commit   (commit),
        .cur_desc (cur_desc),
        .rsp_data (rsp_data),
        .rob_wen  (rob_wen),
        .rob_addr (rob_addr),
        .rob_din  (rob_din),
        .rob_dout (rob_dout)
    );

endmodule

// ==== hw/icm_entry_merge.sv ====
// merges a hit entry into its two-half reorder buffer slot
// assumes an asynchronous-read reorder memory addressed by rob_addr
// rob_addr follows cur_desc, so the old slot is already on rob_dout at commit
// count_index 0 fills the lower half, 1 the upper half, anything else clears
// the slot

module icm_entry_merge (
    input  logic                                clk,
    input  logic                                rst,

    // strobes and descriptor from control
    input  logic                                capture,
    input  logic                                commit,
    input  icm_rsp_pkg::req_desc_t              cur_desc,

    // entry returned with the response
    input  logic [icm_rsp_pkg::entry_width-1:0] rsp_data,

    // reorder buffer port
    output logic                                rob_wen,
    output logic [icm_rsp_pkg::req_tag_width-1:0] rob_addr,
    output icm_rsp_pkg::rob_slot_t              rob_din,
    input  icm_rsp_pkg::rob_slot_t              rob_dout
);

    logic [icm_rsp_pkg::entry_width-1:0] data_q;

    // set between capture and commit of a hit
    logic                                entry_pending;

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= rsp_data;
        end
    end

    // misses capture too but never commit, so a later capture restarts it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entry_pending <= 1'b0;
        end else if (capture) begin
            entry_pending <= 1'b1;
        end else if (commit) begin
            entry_pending <= 1'b0;
        end
    end

    assign rob_addr = cur_desc.req_tag;
    assign rob_wen  = commit;

    // read-modify-write of the slot on rob_dout
    always_comb begin
        rob_din = '0;
        if (commit) begin
            case (cur_desc.count_index)
                2'd0: begin
                    rob_din.collected = rob_dout.collected + 1'b1;
                    rob_din.upper     = rob_dout.upper;
                    rob_din.lower     = data_q;
                end
                2'd1: begin
                    rob_din.collected = rob_dout.collected + 1'b1;
                    rob_din.upper     = data_q;
                    rob_din.lower     = rob_dout.lower;
                end
                default: begin
                    // out of range index leaves an empty slot
                    rob_din = '0;
                end
            endcase
        end
    end

    // a slot write needs an entry captured since the last commit
    a_wen_in_commit: assert property (
        @(posedge clk) disable iff (rst)
        rob_wen |-> entry_pending
    );

endmodule

// ==== hw/icm_rsp_ctrl.sv ====
// control for the ICM response stage, one response in flight at a time
// rsp_ready is high only in idle, so a new response waits for the previous one
// hit and miss queue writes wait while the matching prog_full flag is high
// the miss path issues one single-beat DMA read of entry_bytes bytes
// cur_desc shows the live head in idle and the captured head otherwise

module icm_rsp_ctrl (
    input  logic                   clk,
    input  logic                   rst,

    // lookup response
    input  logic                   rsp_valid,
    input  icm_rsp_pkg::rsp_head_t rsp_head,
    output logic                   rsp_ready,

    // toward the entry merge
    output logic                   capture,
    output logic                   commit,
    output icm_rsp_pkg::req_desc_t cur_desc,

    // hit queue
    output logic                   hit_wr_en,
    output icm_rsp_pkg::req_desc_t hit_din,
    input  logic                   hit_prog_full,

    // miss queue
    output logic                   miss_wr_en,
    output icm_rsp_pkg::req_desc_t miss_din,
    input  logic                   miss_prog_full,

    // DMA read request
    output logic                   dma_req_valid,
    output icm_rsp_pkg::dma_head_t dma_req_head,
    output logic                   dma_req_last,
    input  logic                   dma_req_ready
);

    icm_rsp_pkg::rsp_state_e state;
    icm_rsp_pkg::rsp_state_e state_nxt;

    // head held for the whole life of a response
    icm_rsp_pkg::rsp_head_t  head_q;

    logic                    dma_done;

    assign rsp_ready = (state == icm_rsp_pkg::st_idle);
    assign capture   = rsp_valid && rsp_ready;

    assign dma_done  = dma_req_valid && dma_req_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= icm_rsp_pkg::st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            icm_rsp_pkg::st_idle: begin
                if (capture) begin
                    // hit flag picks the path
                    if (rsp_head.hit) begin
                        state_nxt = icm_rsp_pkg::st_hit;
                    end else begin
                        state_nxt = icm_rsp_pkg::st_miss;
                    end
                end
            end
            icm_rsp_pkg::st_hit: begin
                if (!hit_prog_full) begin
                    state_nxt = icm_rsp_pkg::st_idle;
                end
            end
            icm_rsp_pkg::st_miss: begin
                if (!miss_prog_full) begin
                    state_nxt = icm_rsp_pkg::st_dma;
                end
            end
            icm_rsp_pkg::st_dma: begin
                if (dma_done) begin
                    state_nxt = icm_rsp_pkg::st_idle;
                end
            end
            default: begin
                state_nxt = icm_rsp_pkg::st_idle;
            end
        endcase
    end

    // response head capture
    always_ff @(posedge clk) begin
        if (capture) begin
            head_q <= rsp_head;
        end
    end

    // merge needs the tag before capture to start the slot read
    assign cur_desc = (state == icm_rsp_pkg::st_idle) ? rsp_head.desc : head_q.desc;

    // queue writes, at most one per response
    assign hit_wr_en  = (state == icm_rsp_pkg::st_hit) && !hit_prog_full;
    assign miss_wr_en = (state == icm_rsp_pkg::st_miss) && !miss_prog_full;
    assign hit_din    = head_q.desc;
    assign miss_din   = head_q.desc;

    // reorder write goes out together with the hit queue write
    assign commit = hit_wr_en;

    // single beat, so last follows valid
    assign dma_req_valid = (state == icm_rsp_pkg::st_dma);
    assign dma_req_last  = dma_req_valid;

    always_comb begin
        dma_req_head.phys_addr = head_q.desc.phys_addr;
        dma_req_head.len       = icm_rsp_pkg::dma_len_width'(icm_rsp_pkg::entry_bytes);
    end

    // a response goes to exactly one queue
    a_one_queue: assert property (
        @(posedge clk) disable iff (rst)
        !(hit_wr_en && miss_wr_en)
    );

    // a stalled DMA request keeps valid and head until taken
    a_dma_hold: assert property (
        @(posedge clk) disable iff (rst)
        (dma_req_valid && !dma_req_ready) |=> (dma_req_valid && $stable(dma_req_head))
    );

endmodule

// ==== hw/icm_rsp_pkg.sv ====
// shared widths, state encoding and bus structs for the ICM response stage
// sized for the MTT cache only, one 64-bit entry per response
// a reorder slot always holds two entry halves plus a collected count
// struct field order matches the packed bus layout, high bits first

package icm_rsp_pkg;

    // entry and address widths
    localparam int entry_width     = 64;
    localparam int phys_addr_width = 32;
    localparam int icm_addr_width  = 32;

    // 32 outstanding request tags
    localparam int req_tag_width   = 5;

    // wide enough for index 0..1 and a count up to 2
    localparam int count_width     = 2;

    // DMA head length field
    localparam int dma_len_width   = 32;

    // one entry per DMA read
    localparam int entry_bytes     = entry_width / 8;

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_hit  = 2'd1,
        st_miss = 2'd2,
        st_dma  = 2'd3
    } rsp_state_e;

    // descriptor forwarded to the hit or miss queue
    typedef struct packed {
        logic [count_width-1:0]     count_max;
        logic [count_width-1:0]     count_index;
        logic [req_tag_width-1:0]   req_tag;
        logic [phys_addr_width-1:0] phys_addr;
        logic [icm_addr_width-1:0]  icm_addr;
    } req_desc_t;

    // lookup response head, hit flag on top
    typedef struct packed {
        logic      hit;
        req_desc_t desc;
    } rsp_head_t;

    // reorder buffer slot
    // index 1 lands in upper, index 0 in lower
    typedef struct packed {
        logic [count_width-1:0] collected;
        logic [entry_width-1:0] upper;
        logic [entry_width-1:0] lower;
    } rob_slot_t;

    // single-beat DMA read request head
    typedef struct packed {
        logic [phys_addr_width-1:0] phys_addr;
        logic [dma_len_width-1:0]   len;
    } dma_head_t;

endpackage
